/* design/zports_params.svh */
////////////////////////////////////////////////////////////
// fixed port map of the spectrum I/O block, one byte each
// only the reset values that are not zero live here
////////////////////////////////////////////////////////////
`ifndef ZPORTS_PARAMS_SVH
`define ZPORTS_PARAMS_SVH

`default_nettype none

////////////////////////////////////////////////////////////
// low address byte of the kept ports
`define ZP_PORT_FE      8'hFE   // keyboard, tape in
`define ZP_PORT_FD      8'hFD   // 7FFD paging
`define ZP_PORT_F7      8'hF7   // EFF7 paging
`define ZP_PORT_XT      8'hAF   // extension registers, index in a[15:8]
`define ZP_PORT_BE      8'hBE   // config read-back

////////////////////////////////////////////////////////////
// extension register index, high address byte
`define ZP_XT_RAMPAGE   8'h10   // 10..13, one per 16k window
`define ZP_XT_SYSCONF   8'h20
`define ZP_XT_MEMCONF   8'h21
`define ZP_XT_IM2VECT   8'h25
`define ZP_XT_XTOVERR   8'h2A   // page override mask

// reset values
`define ZP_SYSCONF_RST  8'h02   // turbo on
`define ZP_IM2VECT_RST  8'hFF
`define ZP_RAMPAGE1_RST 8'h05
`define ZP_RAMPAGE2_RST 8'h02

// port BE read select, a[11:8]
`define ZP_BE_SEL_7FFD  4'hA
`define ZP_BE_SEL_EFF7  4'hB

`default_nettype wire

`endif

/* design/zports_pkg.sv */
////////////////////////////////////////////////////////////
// types shared by the port block; compile before the RTL
////////////////////////////////////////////////////////////
`default_nettype none

package zports_pkg;

	// which kept port the current address selects
	typedef enum logic [2:0]
	{
		PS_NONE = 3'd0,
		PS_FE   = 3'd1,
		PS_7FFD = 3'd2,
		PS_EFF7 = 3'd3,
		PS_XT   = 3'd4,
		PS_BE   = 3'd5
	} port_sel_e;

	// one decoded Z80 I/O access
	typedef struct packed
	{
		port_sel_e   sel;
		logic [7:0]  hoa;     // high address byte
		logic [7:0]  din;     // write data
		logic        wr_stb;  // one zclk wide
		logic        rd_stb;
		logic        blk;     // port hidden by shadow mode
		logic        spare;
	} io_req_t;

	// ram pages of the four 16k windows, entry 0 at the bottom
	typedef logic [3:0][7:0] xt_page_t;

	typedef struct packed
	{
		logic [7:0] sysconf;
		logic [7:0] memconf;
		logic [7:0] im2vect;
	} xt_cfg_t;

	// pentagon 1M paging state
	typedef struct packed
	{
		logic [5:0] pent1m_page;  // full page number
		logic       pent1m_rom;   // 7FFD bit 4
		logic       ram0_0;       // EFF7 bit 3
		logic       on1m;         // EFF7 bit 2 inverted
		logic [6:0] spare;
	} pent_map_t;

endpackage

`default_nettype wire

/* design/zio_strobes.sv */
////////////////////////////////////////////////////////////
// control inputs must already be synchronous to zclk
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zio_strobes
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic wr_stb,
	output logic rd_stb
);

	logic iowr;
	logic iord;
	logic iowr_q;   // last cycle level
	logic iord_q;

	assign iowr = !iorq_n && !wr_n;
	assign iord = !iorq_n && !rd_n;

	// rising edge of the bus cycle -> single strobe
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_q <= 1'b0;
			iord_q <= 1'b0;
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
		end
		else
		begin
			iowr_q <= iowr;
			iord_q <= iord;
			wr_stb <= iowr && !iowr_q;
			rd_stb <= iord && !iord_q;
		end
	end

	// a Z80 cycle is either a read or a write, never both
	a_one_dir: assert property (@(posedge zclk) disable iff (!rst_n)
		!(wr_stb && rd_stb));

endmodule

`default_nettype wire

/* design/port_decode.sv */
////////////////////////////////////////////////////////////
// fixed port map; shadow mode comes from dos only
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "zports_params.svh"
`default_nettype none

module port_decode
(
	input  logic [15:0]          a,
	input  logic [7:0]           din,
	input  logic                 dos,
	input  logic                 wr_stb,
	input  logic                 rd_stb,
	output zports_pkg::io_req_t  req,
	output logic                 porthit
);

	logic [7:0]             loa;
	zports_pkg::port_sel_e  sel;

	assign loa = a[7:0];

	always_comb
	begin
		sel = zports_pkg::PS_NONE;
		case (loa)
			`ZP_PORT_FE: sel = zports_pkg::PS_FE;
			`ZP_PORT_FD:
				if (!a[15])  // a[15] high is the AY, not ours
					sel = zports_pkg::PS_7FFD;
			`ZP_PORT_F7:
				if (a[8] && !a[12] && !dos)
					sel = zports_pkg::PS_EFF7;
			`ZP_PORT_XT: sel = zports_pkg::PS_XT;
			`ZP_PORT_BE: sel = zports_pkg::PS_BE;
			default:     sel = zports_pkg::PS_NONE;
		endcase
	end

	// external bus sees iorq only for ports nobody here answers
	assign porthit = (loa == `ZP_PORT_FE) ||
	                 (loa == `ZP_PORT_FD) ||
	                 (loa == `ZP_PORT_XT) ||
	                 (loa == `ZP_PORT_BE) ||
	                 ((loa == `ZP_PORT_F7) && !dos);

	assign req = '{
		sel:    sel,
		hoa:    a[15:8],
		din:    din,
		wr_stb: wr_stb,
		rd_stb: rd_stb,
		blk:    (loa == `ZP_PORT_F7) && dos,   // F7 hidden in shadow
		spare:  1'b0
	};

endmodule

`default_nettype wire

/* design/xt_regs.sv */
////////////////////////////////////////////////////////////
// extension registers behind nnAF, index in the high byte
// unknown indices are ignored on write
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "zports_params.svh"
`default_nettype none

module xt_regs
(
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zports_pkg::io_req_t   req,
	input  logic                  seven_ffd_wr,
	output zports_pkg::xt_page_t  xt_page,
	output zports_pkg::xt_cfg_t   xt_cfg,
	output logic [3:0]            xt_override
);

	logic xt_wr;
	logic xt_stb;     // any access to nnAF
	logic page_wr;
	logic ovr_wr;

	assign xt_stb  = (req.wr_stb || req.rd_stb) && (req.sel == zports_pkg::PS_XT);
	assign xt_wr   = req.wr_stb && (req.sel == zports_pkg::PS_XT);
	assign page_wr = xt_wr && ((req.hoa & 8'hFC) == `ZP_XT_RAMPAGE);  // 10..13
	assign ovr_wr  = xt_wr && (req.hoa == `ZP_XT_XTOVERR);

	////////////////////////////////////////////////////////////
	// register file
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			xt_page <= {8'h00, `ZP_RAMPAGE2_RST, `ZP_RAMPAGE1_RST, 8'h00};
			xt_cfg  <= '{sysconf: `ZP_SYSCONF_RST, memconf: 8'h00,
			             im2vect: `ZP_IM2VECT_RST};
		end
		else if (xt_wr)
		begin
			if (page_wr)
				xt_page[req.hoa[1:0]] <= req.din;
			if (req.hoa == `ZP_XT_SYSCONF)
				xt_cfg.sysconf <= req.din;
			if (req.hoa == `ZP_XT_MEMCONF)
				xt_cfg.memconf <= req.din;
			if (req.hoa == `ZP_XT_IM2VECT)
				xt_cfg.im2vect <= req.din;
		end
	end

	////////////////////////////////////////////////////////////
	// override mask, decides xt page vs 7FFD for each window
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			xt_override <= 4'b0000;
		else if (ovr_wr)
			xt_override <= req.din[3:0];   // direct load wins
		else
		begin
			if (page_wr)
				xt_override[req.hoa[1:0]] <= 1'b1;
			if (seven_ffd_wr)
				xt_override[3] <= 1'b0;   // C000 window back to 7FFD
		end
	end

	// 7FFD write comes from the same req, so it cannot overlap nnAF
	a_no_overlap: assert property (@(posedge zclk) disable iff (!rst_n)
		!(xt_stb && seven_ffd_wr));

endmodule

`default_nettype wire

/* design/paging_ports.sv */
////////////////////////////////////////////////////////////
// pentagon 1M paging; only rstrom[0] picks the reset rom
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module paging_ports
(
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic [1:0]             rstrom,
	input  zports_pkg::io_req_t    req,
	output logic                   seven_ffd_wr,
	output zports_pkg::pent_map_t  pmap,
	output logic [7:0]             p7ffd,
	output logic [7:0]             peff7    // unmasked
);

	logic       block7ffd;   // 7FFD locked until reset
	logic       block1m;
	logic       eff7_wr;
	logic       rom_q;
	logic [5:0] page_q;

	assign block1m      = peff7[2];
	assign seven_ffd_wr = req.wr_stb && (req.sel == zports_pkg::PS_7FFD) && !block7ffd;
	assign eff7_wr      = req.wr_stb && (req.sel == zports_pkg::PS_EFF7);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= 8'h00;
			peff7     <= 8'h00;
			block7ffd <= 1'b0;
			page_q    <= 6'd0;
			rom_q     <= rstrom[0];
		end
		else
		begin
			if (seven_ffd_wr)
			begin
				p7ffd     <= req.din;
				rom_q     <= req.din[4];
				block7ffd <= p7ffd[5] & block1m;
				// 128k mode keeps the upper page bits at zero
				page_q    <= {block1m ? 3'b000 : {req.din[5], req.din[7:6]}, req.din[2:0]};
			end
			if (eff7_wr)
				peff7 <= req.din;
		end
	end

	always_comb
	begin
		pmap.pent1m_page = page_q;
		pmap.pent1m_rom  = rom_q;
		pmap.ram0_0      = peff7[3];
		pmap.on1m        = !block1m;
		pmap.spare       = 7'd0;
	end

endmodule

`default_nettype wire

/* design/rd_mux.sv */
////////////////////////////////////////////////////////////
// read-back to the Z80; F7 is not driven back, reads FF
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "zports_params.svh"
`default_nettype none

module rd_mux
(
	input  logic [15:0]           a,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  zports_pkg::xt_page_t  xt_page,
	input  logic [7:0]            p7ffd,
	input  logic [7:0]            peff7,
	output logic [7:0]            dout,
	output logic                  dataout
);

	logic hit;   // we own the data bus for this port

	always_comb
	begin
		dout = 8'hFF;
		hit  = 1'b0;
		case (a[7:0])
			`ZP_PORT_FE:
			begin
				hit  = 1'b1;
				dout = {1'b1, tape_read, 1'b0, keys_in};
			end
			`ZP_PORT_FD: hit = 1'b1;   // write only, reads FF
			`ZP_PORT_XT:
			begin
				hit = 1'b1;
				case (a[15:8])
					`ZP_XT_RAMPAGE + 8'd2: dout = xt_page[2];
					`ZP_XT_RAMPAGE + 8'd3: dout = xt_page[3];
					default:               dout = 8'hFF;
				endcase
			end
			`ZP_PORT_BE:
			begin
				hit = 1'b1;
				case (a[11:8])
					`ZP_BE_SEL_7FFD: dout = p7ffd;
					`ZP_BE_SEL_EFF7: dout = peff7;
					default:         dout = 8'hFF;
				endcase
			end
			default: hit = 1'b0;
		endcase
	end

	assign dataout = hit && !iorq_n && !rd_n;

endmodule

`default_nettype wire

/* design/zports_top.sv */
////////////////////////////////////////////////////////////
// Z80 port block, single zclk domain, no wait states
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zports_top
(
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic [15:0]            a,
	input  logic [7:0]             din,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   dos,
	input  logic [1:0]             rstrom,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	output logic [7:0]             dout,
	output logic                   dataout,
	output logic                   porthit,
	output zports_pkg::xt_page_t   xt_page,
	output zports_pkg::xt_cfg_t    xt_cfg,
	output logic [3:0]             xt_override,
	output zports_pkg::pent_map_t  pmap,
	output logic [7:0]             peff7
);

	logic                 wr_stb;
	logic                 rd_stb;
	logic                 seven_ffd_wr;
	logic [7:0]           p7ffd;
	logic [7:0]           peff7_raw;
	zports_pkg::io_req_t  req;

	zio_strobes u_strobes (.zclk(zclk), .rst_n(rst_n), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .wr_stb(wr_stb), .rd_stb(rd_stb));

	port_decode u_decode (.a(a), .din(din), .dos(dos), .wr_stb(wr_stb), .rd_stb(rd_stb),
		.req(req), .porthit(porthit));

	xt_regs u_xt (.zclk(zclk), .rst_n(rst_n), .req(req), .seven_ffd_wr(seven_ffd_wr),
		.xt_page(xt_page), .xt_cfg(xt_cfg), .xt_override(xt_override));

	paging_ports u_paging (.zclk(zclk), .rst_n(rst_n), .rstrom(rstrom), .req(req),
		.seven_ffd_wr(seven_ffd_wr), .pmap(pmap), .p7ffd(p7ffd), .peff7(peff7_raw));

	rd_mux u_rd (.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .keys_in(keys_in),
		.tape_read(tape_read), .xt_page(xt_page), .p7ffd(p7ffd), .peff7(peff7_raw),
		.dout(dout), .dataout(dataout));

	// 1M blocked: only bits 7,5,4,0 reach the rest of the machine
	assign peff7 = pmap.on1m ? peff7_raw
	                         : {peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]};

endmodule

`default_nettype wire

/* verif/zports_tb.sv */
////////////////////////////////////////////////////////////
// table-driven testbench, stops at the first mismatch
// expected values are hand-computed from the port rules
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zports_tb;

	localparam int stb_timeout = 8;   // cycles allowed for a strobe
	localparam int max_tests   = 32;

	typedef enum logic [1:0] { OP_CHK, OP_WR, OP_RD } op_e;
	typedef enum logic [2:0] { K_PAGE, K_CFG, K_OVR, K_MAP, K_PEFF7, K_RD } kind_e;

	// K_RD packs {porthit, dataout, dout} into exp[9:0]
	typedef struct
	{
		string       name;
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic        dos;
		kind_e       kind;
		logic [31:0] exp;
	} test_t;

	logic                  zclk;
	logic                  rst_n;
	logic [15:0]           a;
	logic [7:0]            din;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic                  dos;
	logic [1:0]            rstrom;
	logic [4:0]            keys_in;
	logic                  tape_read;
	logic [7:0]            dout;
	logic                  dataout;
	logic                  porthit;
	zports_pkg::xt_page_t  xt_page;
	zports_pkg::xt_cfg_t   xt_cfg;
	logic [3:0]            xt_override;
	zports_pkg::pent_map_t pmap;
	logic [7:0]            peff7;

	test_t tbl [max_tests];
	int    n_tests;

	zports_top u_dut (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .rstrom(rstrom), .keys_in(keys_in),
		.tape_read(tape_read), .dout(dout), .dataout(dataout), .porthit(porthit),
		.xt_page(xt_page), .xt_cfg(xt_cfg), .xt_override(xt_override), .pmap(pmap),
		.peff7(peff7));

	always #4 zclk = ~zclk;

	////////////////////////////////////////////////////////////
	// compare tasks
	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_page(input string name, input zports_pkg::xt_page_t exp,
		input zports_pkg::xt_page_t act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_cfg(input string name, input zports_pkg::xt_cfg_t exp,
		input zports_pkg::xt_cfg_t act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_override(input string name, input logic [3:0] exp,
		input logic [3:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_map(input string name, input zports_pkg::pent_map_t exp,
		input zports_pkg::pent_map_t act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	function automatic zports_pkg::pent_map_t map_of(input logic [5:0] page, input logic rom,
		input logic ram0, input logic on1m);
		zports_pkg::pent_map_t m;
		m             = '0;
		m.pent1m_page = page;
		m.pent1m_rom  = rom;
		m.ram0_0      = ram0;
		m.on1m        = on1m;
		return m;
	endfunction

	task automatic add_test(input string name, input op_e op, input logic [15:0] addr,
		input logic [7:0] data, input logic dos_lvl, input kind_e kind, input logic [31:0] exp);
		tbl[n_tests] = '{name, op, addr, data, dos_lvl, kind, exp};
		n_tests++;
	endtask

	task automatic check_state(input test_t t);
		case (t.kind)
			K_PAGE:  check_page(t.name, t.exp, xt_page);
			K_CFG:   check_cfg(t.name, t.exp[23:0], xt_cfg);
			K_OVR:   check_override(t.name, t.exp[3:0], xt_override);
			K_MAP:   check_map(t.name, t.exp[15:0], pmap);
			K_PEFF7: check_byte(t.name, t.exp[7:0], peff7);
			default: ;   // reads are checked inside the bus cycle
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// one Z80 I/O cycle, held 3 clocks
	task automatic bus_cycle(input test_t t);
		int   cnt;
		logic seen;
		cnt  = 0;
		seen = 1'b0;
		@(posedge zclk);
		a      <= t.addr;
		din    <= t.data;
		dos    <= t.dos;
		iorq_n <= 1'b0;
		if (t.op == OP_WR)
			wr_n <= 1'b0;
		else
			rd_n <= 1'b0;
		while (!seen && cnt < stb_timeout)
		begin
			@(negedge zclk);
			seen = (t.op == OP_WR) ? u_dut.wr_stb : u_dut.rd_stb;
			cnt++;
		end
		if (!seen)
		begin
			$display("TIMEOUT: no I/O strobe within %0d cycles in %s", stb_timeout, t.name);
			abort_run();
		end
		@(posedge zclk);
		@(negedge zclk);   // bus still driven here
		if (t.kind == K_RD)
		begin
			check_byte(t.name, t.exp[7:0], dout);
			check_flag({t.name, " dataout"}, t.exp[8], dataout);
			check_flag({t.name, " porthit"}, t.exp[9], porthit);
		end
		@(posedge zclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		rd_n   <= 1'b1;
		@(negedge zclk);
	endtask

	task automatic build_table();
		// reset state, rstrom[0] = 1
		add_test("reset_cfg", OP_CHK, 16'h0000, 8'h00, 1'b0, K_CFG, 32'h000200FF);
		add_test("reset_page", OP_CHK, 16'h0000, 8'h00, 1'b0, K_PAGE, 32'h00020500);
		add_test("reset_ovr", OP_CHK, 16'h0000, 8'h00, 1'b0, K_OVR, 32'h0);
		add_test("reset_map", OP_CHK, 16'h0000, 8'h00, 1'b0, K_MAP,
			{16'h0000, map_of(6'h00, 1'b1, 1'b0, 1'b1)});
		add_test("fe_read", OP_RD, 16'h00FE, 8'h00, 1'b0, K_RD, 32'h3D5);   // 1,tape,0,keys
		// extension registers
		add_test("page0_wr", OP_WR, 16'h10AF, 8'h11, 1'b0, K_PAGE, 32'h00020511);
		add_test("page1_wr", OP_WR, 16'h11AF, 8'h22, 1'b0, K_PAGE, 32'h00022211);
		add_test("page2_wr", OP_WR, 16'h12AF, 8'h33, 1'b0, K_PAGE, 32'h00332211);
		add_test("page3_wr", OP_WR, 16'h13AF, 8'h44, 1'b0, K_PAGE, 32'h44332211);
		add_test("ovr_pages", OP_CHK, 16'h13AF, 8'h00, 1'b0, K_OVR, 32'hF);
		add_test("sysconf_wr", OP_WR, 16'h20AF, 8'h03, 1'b0, K_CFG, 32'h000300FF);
		add_test("memconf_wr", OP_WR, 16'h21AF, 8'h5A, 1'b0, K_CFG, 32'h00035AFF);
		add_test("im2vect_wr", OP_WR, 16'h25AF, 8'h7E, 1'b0, K_CFG, 32'h00035A7E);
		add_test("page2_rd", OP_RD, 16'h12AF, 8'h00, 1'b0, K_RD, 32'h333);
		add_test("page3_rd", OP_RD, 16'h13AF, 8'h00, 1'b0, K_RD, 32'h344);
		// 7FFD, page {1,11,011}
		add_test("p7ffd_wr", OP_WR, 16'h7FFD, 8'hE3, 1'b0, K_MAP,
			{16'h0000, map_of(6'h3B, 1'b0, 1'b0, 1'b1)});
		add_test("ovr_7ffd", OP_CHK, 16'h7FFD, 8'h00, 1'b0, K_OVR, 32'h7);
		add_test("xtoverr_wr", OP_WR, 16'h2AAF, 8'h05, 1'b0, K_OVR, 32'h5);
		// 1M blocked by EFF7 bit 2
		add_test("eff7_wr", OP_WR, 16'hEFF7, 8'hBD, 1'b0, K_PEFF7, 32'hB1);
		add_test("map_1m_blocked", OP_CHK, 16'hEFF7, 8'h00, 1'b0, K_MAP,
			{16'h0000, map_of(6'h3B, 1'b0, 1'b1, 1'b0)});
		add_test("p7ffd_blk_wr", OP_WR, 16'h7FFD, 8'hD5, 1'b0, K_MAP,
			{16'h0000, map_of(6'h05, 1'b1, 1'b1, 1'b0)});
		add_test("be_eff7_rd", OP_RD, 16'h0BBE, 8'h00, 1'b0, K_RD, 32'h3BD);   // raw byte
		add_test("be_7ffd_rd", OP_RD, 16'h0ABE, 8'h00, 1'b0, K_RD, 32'h3D5);
		// shadow mode
		add_test("eff7_dos_wr", OP_WR, 16'hEFF7, 8'h00, 1'b1, K_PEFF7, 32'hB1);
		add_test("f7_dos_rd", OP_RD, 16'hEFF7, 8'h00, 1'b1, K_RD, 32'h0FF);
		add_test("unmapped_rd", OP_RD, 16'h001F, 8'h00, 1'b0, K_RD, 32'h0FF);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		int i;
		zclk      = 1'b0;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		rstrom    = 2'b01;
		keys_in   = 5'h15;
		tape_read = 1'b1;
		n_tests   = 0;
		build_table();
		repeat (16) @(posedge zclk);
		rst_n <= 1'b1;
		for (i = 0; i < n_tests; i++)
		begin
			if (tbl[i].op == OP_CHK)
				@(negedge zclk);
			else
				bus_cycle(tbl[i]);
			check_state(tbl[i]);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/zports_pkg.sv
design/zio_strobes.sv
design/port_decode.sv
design/xt_regs.sv
design/paging_ports.sv
design/rd_mux.sv
design/zports_top.sv
verif/zports_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the zports testbench with Verilator, runs it, checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sources.f --top-module zports_tb --Mdir obj_dir -o zports_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/zports_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
